// File: build.f
+incdir+.
mix_data_pkg.sv
mix_flow_pkg.sv
lane_prep.sv
mix_round.sv
cascade_stage.sv
final_affine.sv
mix_top.sv
tb_mix_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mix pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_mix_top -f build.f \
    -o Vtb_mix_top || exit 1

./obj_dir/Vtb_mix_top | tee /dev/stderr | grep "sim passed" > /dev/null && exit 0 || exit 1

// File: tb_mix_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mix_config.svh"

module tb_mix_top;

    localparam int LATENCY    = `MIX_ROUNDS + 3;
    localparam int WAIT_LIMIT = 100;

    // final multiply-add tables
    localparam logic [31:0] aff_mul1 [8] = '{2, 3, 5, 7, 11, 13, 17, 19};
    localparam logic [31:0] aff_add1 [8] = '{3, 5, 7, 11, 13, 17, 19, 23};
    localparam logic [31:0] aff_mul2 [8] = '{2, 3, 3, 3, 5, 13, 35, 87};
    localparam logic [31:0] aff_add2 [8] = '{0, 1, 8, 27, 64, 125, 216, 343};

    logic                    clk = 1'b0;
    logic                    rst;
    mix_flow_pkg::mix_beat_t in_beat;
    mix_flow_pkg::mix_beat_t out_beat;

    logic [31:0]              rng = 32'h255c_4626;
    logic [`MIX_TAG_W-1:0]    tag_seq = '0;
    int                       cyc = 0;
    int                       out_cnt = 0;
    mix_flow_pkg::mix_beat_t  exp_q [$];
    int                       exp_cyc_q [$];
    mix_flow_pkg::mix_beat_t  mon_exp;
    mix_data_pkg::mix_state_t last_state;

    mix_top dut (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (in_beat),
        .out_beat (out_beat)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic mix_data_pkg::mix_state_t random_state();
        mix_data_pkg::mix_state_t s;
        for (int i = 0; i < `MIX_LANES; i++) begin
            rng = xorshift32(rng);
            s.lane[i].word = rng;
        end
        return s;
    endfunction

    // reference for one block through prep, rounds, cascade and affine
    function automatic mix_data_pkg::mix_state_t model_mix(input mix_data_pkg::mix_state_t s);
        logic [31:0]              l [8];
        mix_data_pkg::mix_state_t r;
        for (int i = 0; i < 8; i++) l[i] = s.lane[i].word + 32'(i);
        l[0] = l[0] + l[7];
        for (int i = 1; i < 8; i++) l[i] = l[i] + l[i-1];
        for (int n = 0; n < `MIX_ROUNDS; n++) begin
            for (int i = 0; i < 8; i++) l[i] = l[i] + l[(i+1)%8] - l[(i+5)%8];
            for (int i = 0; i < 8; i++) l[i] = l[i] ^ {l[(i+3)%8][15:0], 16'h0000};
            for (int i = 0; i < 8; i++) begin
                l[i] = l[i] - (l[(i+2)%8] >> `MIX_SUB_SHIFT) + (l[(i+4)%8] >> `MIX_ADD_SHIFT);
            end
        end
        for (int p = 0; p < `MIX_CASCADE_PASSES; p++) begin
            for (int i = 0; i < 8; i++) l[i] = l[i] + l[(i+7)%8] - l[(i+6)%8];
        end
        for (int i = 0; i < 8; i++) l[i] = l[i] * aff_mul1[i] + aff_add1[i];
        for (int i = 0; i < 8; i++) l[i] = l[i] * aff_mul2[i] + aff_add2[i];
        for (int i = 0; i < 8; i++) r.lane[i].word = l[i];
        return r;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_val(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %s got %0h expected %0h", name, got, exp));
        end
    endtask

    task automatic send_block(input mix_data_pkg::mix_state_t st);
        mix_flow_pkg::mix_beat_t b;
        mix_flow_pkg::mix_beat_t e;
        @(posedge clk);
        b.valid = 1'b1;
        b.tag   = tag_seq;
        b.state = st;
        in_beat <= b;
        e       = b;
        e.state = model_mix(st);
        exp_q.push_back(e);
        exp_cyc_q.push_back(cyc + 1 + LATENCY);  // drive lands after edge cyc+1
        tag_seq++;
    endtask

    // junk payload with valid low, the DUT must ignore it
    task automatic idle_cycle();
        mix_flow_pkg::mix_beat_t b;
        @(posedge clk);
        b.valid = 1'b0;
        b.tag   = rng[`MIX_TAG_W-1:0];
        b.state = random_state();
        in_beat <= b;
    endtask

    task automatic wait_drain();
        for (int k = 0; k < WAIT_LIMIT && exp_q.size() != 0; k++) begin
            idle_cycle();
        end
        if (exp_q.size() != 0) stop_with_error("timeout waiting for the pipeline to drain");
    endtask

    // scoreboard, sampled away from the drive edge
    always @(negedge clk) begin
        if (cyc > 0) begin
            if (out_beat.valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    stop_with_error("out_beat valid high with no block in flight");
                end else begin
                    mon_exp = exp_q.pop_front();
                    check_val("out_beat arrival cycle", 256'(cyc), 256'(exp_cyc_q.pop_front()));
                    check_val("out_beat.tag", 256'(out_beat.tag), 256'(mon_exp.tag));
                    check_val("out_beat.state", 256'(out_beat.state), 256'(mon_exp.state));
                    last_state = out_beat.state;
                    out_cnt++;
                end
            end else if (out_beat.valid !== 1'b0) begin
                stop_with_error("out_beat valid is unknown");
            end else if (exp_cyc_q.size() != 0 && cyc >= exp_cyc_q[0]) begin
                stop_with_error("expected block did not appear at out_beat");
            end
        end
    end

    initial begin : stim
        mix_data_pkg::mix_state_t cur;
        mix_data_pkg::mix_state_t ref_st;
        int                       prev;
        int                       k;
        in_beat = '0;
        rst     = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // quiet pipeline after reset
        repeat (10) idle_cycle();

        // single block
        send_block(random_state());
        wait_drain();

        // back to back burst
        for (int n = 0; n < 200; n++) send_block(random_state());
        wait_drain();

        // random gaps
        for (int n = 0; n < 300; n++) begin
            rng = xorshift32(rng);
            if (rng[1:0] != 2'b00) send_block(random_state());
            else idle_cycle();
        end
        wait_drain();

        // feedback iteration from lanes 0..7
        for (int i = 0; i < `MIX_LANES; i++) cur.lane[i].word = 32'(i);
        ref_st = cur;
        for (int n = 0; n < 20; n++) begin
            prev = out_cnt;
            send_block(cur);
            idle_cycle();
            for (k = 0; k < WAIT_LIMIT && out_cnt == prev; k++) @(posedge clk);
            if (out_cnt == prev) stop_with_error("timeout waiting for a feedback result");
            cur    = last_state;
            ref_st = model_mix(ref_st);
            check_val("feedback state", 256'(cur), 256'(ref_st));
        end
        wait_drain();

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: mix_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mix_config.svh"

// latency is MIX_ROUNDS + 3 cycles, one new block accepted per cycle
module mix_top (
    input  wire logic              clk,
    input  wire logic              rst,
    input  mix_flow_pkg::mix_beat_t in_beat,
    output mix_flow_pkg::mix_beat_t out_beat
);

    // round_beat[0] is the prep output, round_beat[MIX_ROUNDS] feeds the cascade
    mix_flow_pkg::mix_beat_t round_beat [`MIX_ROUNDS + 1];
    mix_flow_pkg::mix_beat_t casc_beat;

    lane_prep u_prep (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (in_beat),
        .out_beat (round_beat[0])
    );

    for (genvar r = 0; r < `MIX_ROUNDS; r++) begin : g_round
        mix_round u_round (
            .clk      (clk),
            .rst      (rst),
            .in_beat  (round_beat[r]),
            .out_beat (round_beat[r + 1])
        );
    end

    cascade_stage u_cascade (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (round_beat[`MIX_ROUNDS]),
        .out_beat (casc_beat)
    );

    final_affine u_affine (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (casc_beat),
        .out_beat (out_beat)
    );

endmodule

`default_nettype wire

// File: final_affine.sv
`timescale 1ns/1ps
`default_nettype none

`include "mix_config.svh"

module final_affine (
    input  wire logic              clk,
    input  wire logic              rst,
    input  mix_flow_pkg::mix_beat_t in_beat,
    output mix_flow_pkg::mix_beat_t out_beat
);

    // per-lane coefficients, first pass
    localparam logic [`MIX_WORD_W-1:0] mul_a [`MIX_LANES] = '{2, 3, 5, 7, 11, 13, 17, 19};
    localparam logic [`MIX_WORD_W-1:0] add_a [`MIX_LANES] = '{3, 5, 7, 11, 13, 17, 19, 23};

    // second pass
    localparam logic [`MIX_WORD_W-1:0] mul_b [`MIX_LANES] = '{2, 3, 3, 3, 5, 13, 35, 87};
    localparam logic [`MIX_WORD_W-1:0] add_b [`MIX_LANES] = '{0, 1, 8, 27, 64, 125, 216, 343};

    mix_data_pkg::mix_state_t nxt;

    always_comb begin
        nxt = in_beat.state;
        for (int i = 0; i < `MIX_LANES; i++) begin
            nxt.lane[i].word = nxt.lane[i].word * mul_a[i] + add_a[i];  // wraps mod 2^32
        end
        for (int i = 0; i < `MIX_LANES; i++) begin
            nxt.lane[i].word = nxt.lane[i].word * mul_b[i] + add_b[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_beat.valid <= 1'b0;
        end else begin
            out_beat.valid <= in_beat.valid;
        end

        if (in_beat.valid) begin
            out_beat.tag   <= in_beat.tag;
            out_beat.state <= nxt;
        end
    end

endmodule

`default_nettype wire

// File: cascade_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mix_config.svh"

module cascade_stage (
    input  wire logic              clk,
    input  wire logic              rst,
    input  mix_flow_pkg::mix_beat_t in_beat,
    output mix_flow_pkg::mix_beat_t out_beat
);

    mix_data_pkg::mix_state_t nxt;

    always_comb begin
        nxt = in_beat.state;
        for (int p = 0; p < `MIX_CASCADE_PASSES; p++) begin
            // lane i += lane i-1 - lane i-2, wrapping around lane 0
            for (int i = 0; i < `MIX_LANES; i++) begin
                nxt.lane[i].word = nxt.lane[i].word
                                 + nxt.lane[(i + `MIX_LANES - 1) % `MIX_LANES].word
                                 - nxt.lane[(i + `MIX_LANES - 2) % `MIX_LANES].word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_beat.valid <= 1'b0;
        end else begin
            out_beat.valid <= in_beat.valid;
        end

        if (in_beat.valid) begin
            out_beat.tag   <= in_beat.tag;
            out_beat.state <= nxt;
        end
    end

endmodule

`default_nettype wire

// File: mix_round.sv
`timescale 1ns/1ps
`default_nettype none

`include "mix_config.svh"

module mix_round (
    input  wire logic              clk,
    input  wire logic              rst,
    input  mix_flow_pkg::mix_beat_t in_beat,
    output mix_flow_pkg::mix_beat_t out_beat
);

    mix_data_pkg::mix_state_t nxt;

    // three passes, all in lane order so later lanes see updated ones
    always_comb begin
        nxt = in_beat.state;

        // add-subtract
        for (int i = 0; i < `MIX_LANES; i++) begin
            nxt.lane[i].word = nxt.lane[i].word
                             + nxt.lane[(i + 1) % `MIX_LANES].word
                             - nxt.lane[(i + 5) % `MIX_LANES].word;
        end

        // xor-shift on the half view
        for (int i = 0; i < `MIX_LANES; i++) begin
            nxt.lane[i].half.hi = nxt.lane[i].half.hi
                                ^ nxt.lane[(i + 3) % `MIX_LANES].half.lo;
        end

        // shift-add
        for (int i = 0; i < `MIX_LANES; i++) begin
            nxt.lane[i].word = nxt.lane[i].word
                             - (nxt.lane[(i + 2) % `MIX_LANES].word >> `MIX_SUB_SHIFT)
                             + (nxt.lane[(i + 4) % `MIX_LANES].word >> `MIX_ADD_SHIFT);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_beat.valid <= 1'b0;
        end else begin
            out_beat.valid <= in_beat.valid;
        end

        if (in_beat.valid) begin
            out_beat.tag   <= in_beat.tag;
            out_beat.state <= nxt;
        end
    end

endmodule

`default_nettype wire

// File: lane_prep.sv
`timescale 1ns/1ps
`default_nettype none

`include "mix_config.svh"

module lane_prep (
    input  wire logic              clk,
    input  wire logic              rst,
    input  mix_flow_pkg::mix_beat_t in_beat,
    output mix_flow_pkg::mix_beat_t out_beat
);

    mix_data_pkg::mix_state_t nxt;

    always_comb begin
        nxt = in_beat.state;

        // each lane biased by its own index
        for (int i = 0; i < `MIX_LANES; i++) begin
            nxt.lane[i].word = nxt.lane[i].word + `MIX_WORD_W'(i);
        end

        // lane 0 picks up the biased lane 7, the rest chain off their neighbour
        for (int i = 0; i < `MIX_LANES; i++) begin
            nxt.lane[i].word = nxt.lane[i].word
                             + nxt.lane[(i + `MIX_LANES - 1) % `MIX_LANES].word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_beat.valid <= 1'b0;
        end else begin
            out_beat.valid <= in_beat.valid;
        end

        if (in_beat.valid) begin
            out_beat.tag   <= in_beat.tag;
            out_beat.state <= nxt;  // payload only moves with a block
        end
    end

endmodule

`default_nettype wire

// File: mix_flow_pkg.sv
`default_nettype none

`include "mix_config.svh"

package mix_flow_pkg;

    // one pipeline beat, 265 bits
    typedef struct packed {
        logic                   valid;
        logic [`MIX_TAG_W-1:0]  tag;
        mix_data_pkg::mix_state_t state;
    } mix_beat_t;

endpackage

`default_nettype wire

// File: mix_data_pkg.sv
`default_nettype none

`include "mix_config.svh"

package mix_data_pkg;

    // high/low split of a lane, used by the xor-shift pass
    typedef struct packed {
        logic [`MIX_HALF_W-1:0] hi;
        logic [`MIX_HALF_W-1:0] lo;
    } lane_halves_t;

    typedef union packed {
        logic [`MIX_WORD_W-1:0] word;
        lane_halves_t           half;
    } lane_word_u;

    // lane[0] .. lane[7], 256 bits
    typedef struct packed {
        lane_word_u [`MIX_LANES-1:0] lane;
    } mix_state_t;

endpackage

`default_nettype wire

// File: mix_config.svh
`ifndef MIX_CONFIG_SVH
`define MIX_CONFIG_SVH

// lane geometry
`define MIX_LANES 8
`define MIX_WORD_W 32
`define MIX_HALF_W 16

// sideband tag carried next to each block
`define MIX_TAG_W 8

// pipeline depth knobs
`define MIX_ROUNDS 4          // one register stage per round
`define MIX_CASCADE_PASSES 3  // all folded into a single stage

// shifts used by the shift-add pass of a round
`define MIX_SUB_SHIFT 17
`define MIX_ADD_SHIFT 12

`endif
